// ==== common/mem_defs.svh ====
// geometry macros for the SRAM subsystem, included by the packages and by RTL that sizes arrays
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// the whole subsystem holds 1024 words
`define MEM_ADDR_W 10

// data word and its byte enables
`define MEM_DATA_W 32
`define MEM_BE_W   4

// each cut holds 256 words
`define CUT_ADDR_W 8
`define CUT_NUM    4

`endif

// ==== common/mem_pkg.sv ====
// data-path types shared by the bank, the clear counter and the init sequencer
`include "mem_defs.svh"

package mem_pkg;

    // word address across all four cuts
    typedef logic [`MEM_ADDR_W-1:0] addr_t;

    typedef logic [`MEM_DATA_W-1:0] word_t;

    // byte enables are active low, bit n covers byte n of the word
    typedef logic [`MEM_BE_W-1:0] ben_t;

    // address inside a single cut
    typedef logic [`CUT_ADDR_W-1:0] cut_addr_t;

    // which cut an access targets, taken from the top address bits
    typedef logic [$clog2(`CUT_NUM)-1:0] cut_sel_t;

endpackage

// ==== common/init_pkg.sv ====
// state type of the init sequencer that zeroes the memory after reset and on clear
package init_pkg;

    // CLEARING owns the bank, READY hands it to the external port
    typedef enum logic
    {
        CLEARING = 1'b0,
        READY    = 1'b1
    } init_state_t;

endpackage

// ==== sram_bank/mem_cut.sv ====
// behavioral single-port memory cut with active-low enables and byte writes, used by the bank
`timescale 1ns/100ps
`include "mem_defs.svh"

module mem_cut
(
    input  logic               CLK,
    input  logic               cen,
    input  logic               wen,
    input  mem_pkg::ben_t      ben,
    input  mem_pkg::cut_addr_t a,
    input  mem_pkg::word_t     d,
    output mem_pkg::word_t     q
);
    import mem_pkg::*;

    localparam int BYTE_W = `MEM_DATA_W / `MEM_BE_W;

    word_t mem [0:(1 << `CUT_ADDR_W)-1];
    word_t bit_mask;

    // expand the active-low byte enables into a per-bit write mask
    always_comb
    begin
        for (int i = 0; i < `MEM_BE_W; i++)
        begin
            bit_mask[i*BYTE_W +: BYTE_W] = {BYTE_W{~ben[i]}};
        end
    end

    // q only moves on a read, so it holds across writes and idle cycles
    always_ff @(posedge CLK)
    begin
        if (!cen)
        begin
            if (!wen)
            begin
                mem[a] <= (mem[a] & ~bit_mask) | (d & bit_mask);
            end
            else
            begin
                q <= mem[a];
            end
        end
    end

endmodule

// ==== sram_bank/sram_bank.sv ====
// four-cut SRAM bank that decodes per-cut chip enables and muxes the read data back
`timescale 1ns/100ps
`include "mem_defs.svh"

module sram_bank
(
    input  logic           CLK,
    input  logic           RSTN,
    input  logic           cen,
    input  logic           wen,
    input  mem_pkg::ben_t  ben,
    input  mem_pkg::addr_t a,
    input  mem_pkg::word_t d,
    output mem_pkg::word_t q
);
    import mem_pkg::*;

    cut_sel_t              cut_sel;
    cut_sel_t              muxsel;
    cut_addr_t             cut_addr;
    logic [`CUT_NUM-1:0]   cut_cen;
    word_t                 q_int [`CUT_NUM];

    // upper bits pick the cut, lower bits address the word inside it
    assign cut_sel  = a[`MEM_ADDR_W-1:`CUT_ADDR_W];
    assign cut_addr = a[`CUT_ADDR_W-1:0];

    // the mux select follows the last read so q keeps that word
    // while writes to other cuts go by
    always_ff @(posedge CLK or negedge RSTN)
    begin
        if (!RSTN)
        begin
            muxsel <= '0;
        end
        else if (!cen && wen)
        begin
            muxsel <= cut_sel;
        end
    end

    assign q = q_int[muxsel];

    for (genvar i = 0; i < `CUT_NUM; i++)
    begin : cut_g
        // a cut is enabled only when the bank is enabled and the address falls in it
        assign cut_cen[i] = cen | (cut_sel != cut_sel_t'(i));

        mem_cut cut_i
        (
            .CLK ( CLK        ),
            .cen ( cut_cen[i] ),
            .wen ( wen        ),
            .ben ( ben        ),
            .a   ( cut_addr   ),
            .d   ( d          ),
            .q   ( q_int[i]   )
        );
    end

    // two cuts driven at once would mean the decode is broken
    cut_enable_onehot_a: assert property (
        @(posedge CLK) disable iff (!RSTN) $onehot0(~cut_cen)
    ) else $error("more than one cut enabled: %b", ~cut_cen);

endmodule

// ==== logic/word_counter.sv ====
// address counter that walks every memory word during a clear and flags the final one
`timescale 1ns/100ps

module word_counter
(
    input  logic           CLK,
    input  logic           RSTN,
    input  logic           count,
    input  logic           restart,
    output mem_pkg::addr_t addr,
    output logic           last
);
    import mem_pkg::*;

    localparam addr_t LAST_ADDR = '1;

    // restart wins so a new clear always begins at word 0
    always_ff @(posedge CLK or negedge RSTN)
    begin
        if (!RSTN)
        begin
            addr <= '0;
        end
        else if (restart)
        begin
            addr <= '0;
        end
        else if (count)
        begin
            addr <= last ? '0 : addr + 1'b1;
        end
    end

    assign last = (addr == LAST_ADDR);

    // the sequencer restarts only from READY, where it never counts
    no_restart_while_count_a: assert property (
        @(posedge CLK) disable iff (!RSTN) !(restart && count)
    ) else $error("counter restart and count asserted together");

endmodule

// ==== logic/init_sequencer.sv ====
// FSM that zeroes the memory after reset and on clear, then hands the bank to the external port
`timescale 1ns/100ps

module init_sequencer
(
    input  logic           CLK,
    input  logic           RSTN,
    input  logic           clear,
    input  logic           cen,
    input  logic           wen,
    input  mem_pkg::ben_t  ben,
    input  mem_pkg::addr_t addr,
    input  mem_pkg::word_t d,
    input  mem_pkg::addr_t cnt_addr,
    input  logic           cnt_last,
    output logic           cnt_count,
    output logic           cnt_restart,
    output logic           busy,
    output logic           bank_cen,
    output logic           bank_wen,
    output mem_pkg::ben_t  bank_ben,
    output mem_pkg::addr_t bank_addr,
    output mem_pkg::word_t bank_d
);
    import init_pkg::*;

    init_state_t state;

    // the write of the last word is also the edge that leaves CLEARING
    always_ff @(posedge CLK or negedge RSTN)
    begin
        if (!RSTN)
        begin
            state <= CLEARING;
        end
        else
        begin
            case (state)
                CLEARING:
                begin
                    if (cnt_last)
                        state <= READY;
                end
                READY:
                begin
                    if (clear)
                        state <= CLEARING;
                end
                default:
                begin
                    state <= CLEARING;
                end
            endcase
        end
    end

    assign busy = (state == CLEARING);

    always_comb
    begin
        cnt_count   = 1'b0;
        cnt_restart = 1'b0;
        bank_cen    = 1'b1;
        bank_wen    = 1'b1;
        bank_ben    = '1;
        bank_addr   = addr;
        bank_d      = d;
        if (busy)
        begin
            // full-word zero write at the counter address, external port is ignored
            cnt_count = 1'b1;
            bank_cen  = 1'b0;
            bank_wen  = 1'b0;
            bank_ben  = '0;
            bank_addr = cnt_addr;
            bank_d    = '0;
        end
        else
        begin
            cnt_restart = clear;
            bank_cen    = cen;
            bank_wen    = wen;
            bank_ben    = ben;
        end
    end

    // the clear walk must reach the bank exactly at the counter address
    clear_addr_a: assert property (
        @(posedge CLK) disable iff (!RSTN) busy |-> (bank_addr == cnt_addr)
    ) else $error("bank address %0d differs from clear address %0d", bank_addr, cnt_addr);

endmodule

// ==== logic/mem_subsys.sv ====
// top level of the SRAM subsystem, joining the init sequencer, the clear counter and the bank
`timescale 1ns/100ps

module mem_subsys
(
    input  logic           CLK,
    input  logic           RSTN,
    input  logic           cen,
    input  logic           wen,
    input  mem_pkg::ben_t  ben,
    input  mem_pkg::addr_t addr,
    input  mem_pkg::word_t d,
    input  logic           clear,
    output mem_pkg::word_t q,
    output logic           busy
);
    import mem_pkg::*;

    addr_t cnt_addr;
    logic  cnt_last;
    logic  cnt_count;
    logic  cnt_restart;

    logic  bank_cen;
    logic  bank_wen;
    ben_t  bank_ben;
    addr_t bank_addr;
    word_t bank_d;

    init_sequencer seq_i
    (
        .CLK         ( CLK         ),
        .RSTN        ( RSTN        ),
        .clear       ( clear       ),
        .cen         ( cen         ),
        .wen         ( wen         ),
        .ben         ( ben         ),
        .addr        ( addr        ),
        .d           ( d           ),
        .cnt_addr    ( cnt_addr    ),
        .cnt_last    ( cnt_last    ),
        .cnt_count   ( cnt_count   ),
        .cnt_restart ( cnt_restart ),
        .busy        ( busy        ),
        .bank_cen    ( bank_cen    ),
        .bank_wen    ( bank_wen    ),
        .bank_ben    ( bank_ben    ),
        .bank_addr   ( bank_addr   ),
        .bank_d      ( bank_d      )
    );

    word_counter cnt_i
    (
        .CLK     ( CLK         ),
        .RSTN    ( RSTN        ),
        .count   ( cnt_count   ),
        .restart ( cnt_restart ),
        .addr    ( cnt_addr    ),
        .last    ( cnt_last    )
    );

    sram_bank bank_i
    (
        .CLK  ( CLK       ),
        .RSTN ( RSTN      ),
        .cen  ( bank_cen  ),
        .wen  ( bank_wen  ),
        .ben  ( bank_ben  ),
        .a    ( bank_addr ),
        .d    ( bank_d    ),
        .q    ( q         )
    );

endmodule

// ==== dv/mem_checker.sv ====
// checker for the SRAM subsystem testbench, compares read data and busy lengths and keeps counts
`timescale 1ns/100ps

module mem_checker
#(
    parameter int NAME_W = 128
)
(
    input  logic              CLK,
    input  logic              RSTN,
    input  mem_pkg::word_t    q,
    input  logic              busy,
    input  logic              chk_req,
    input  int                chk_idx,
    input  logic [NAME_W-1:0] chk_name,
    input  mem_pkg::word_t    chk_exp,
    output int                pass_cnt,
    output int                fail_cnt
);
    import mem_pkg::*;

    // a clear writes each of the 1024 words once
    localparam int CLEAR_CYCLES = 1024;

    logic              pend;
    int                pend_idx;
    logic [NAME_W-1:0] pend_name;
    word_t             pend_exp;
    int                busy_cycles;
    int                busy_runs;

    // names arrive right-aligned with zero bytes in front
    function automatic string name_text(input logic [NAME_W-1:0] bits);
        string s;
        s = "";
        for (int i = NAME_W/8 - 1; i >= 0; i--)
        begin
            if (bits[i*8 +: 8] != 8'h00)
                s = $sformatf("%s%c", s, bits[i*8 +: 8]);
        end
        return s;
    endfunction

    // a request seen at an edge belongs to the access that edge performs
    always @(posedge CLK)
    begin
        pend      <= chk_req;
        pend_idx  <= chk_idx;
        pend_name <= chk_name;
        pend_exp  <= chk_exp;
    end

    // q and busy are sampled half a cycle after the edge that moved them
    always @(negedge CLK)
    begin
        if (!RSTN)
        begin
            pass_cnt    = 0;
            fail_cnt    = 0;
            busy_cycles = 0;
            busy_runs   = 0;
        end
        else
        begin
            if (pend)
            begin
                if (q === pend_exp)
                begin
                    $display("Pass [%0d] %s", pend_idx, name_text(pend_name));
                    pass_cnt++;
                end
                else
                begin
                    $display("Fail [%0d] %s expected %h actual %h", pend_idx,
                             name_text(pend_name), pend_exp, q);
                    fail_cnt++;
                end
            end
            if (busy)
                busy_cycles++;
            else if (busy_cycles != 0)
            begin
                if (busy_cycles == CLEAR_CYCLES)
                begin
                    $display("Pass busy run %0d lasted %0d cycles", busy_runs, busy_cycles);
                    pass_cnt++;
                end
                else
                begin
                    $display("Error: busy run %0d lasted %0d cycles instead of %0d",
                             busy_runs, busy_cycles, CLEAR_CYCLES);
                    fail_cnt++;
                end
                busy_runs++;
                busy_cycles = 0;
            end
        end
    end

endmodule

// ==== dv/tb_mem_subsys.sv ====
// testbench top for the SRAM subsystem, replays the operations in dv/mem_vectors.txt on the DUT
`timescale 1ns/100ps

module tb_mem_subsys;
    import mem_pkg::*;

    localparam int NAME_W       = 128;
    localparam int CLEAR_CYCLES = 1 << $bits(addr_t);

    logic              CLK;
    logic              RSTN;
    logic              cen;
    logic              wen;
    ben_t              ben;
    addr_t             addr;
    word_t             d;
    logic              clear;
    word_t             q;
    logic              busy;

    logic              chk_req;
    int                chk_idx;
    logic [NAME_W-1:0] chk_name;
    word_t             chk_exp;
    int                pass_cnt;
    int                fail_cnt;

    logic [NAME_W-1:0] vec_name [$];
    logic [63:0]       vec_op [$];
    addr_t             vec_addr [$];
    ben_t              vec_ben [$];
    word_t             vec_data [$];
    word_t             vec_exp [$];
    int                n_clear;
    int                vec_errors;
    int                cycles;
    int                cycle_limit;

    mem_subsys dut_i
    (
        .CLK   ( CLK   ),
        .RSTN  ( RSTN  ),
        .cen   ( cen   ),
        .wen   ( wen   ),
        .ben   ( ben   ),
        .addr  ( addr  ),
        .d     ( d     ),
        .clear ( clear ),
        .q     ( q     ),
        .busy  ( busy  )
    );

    mem_checker #(.NAME_W(NAME_W)) checker_i
    (
        .CLK      ( CLK      ),
        .RSTN     ( RSTN     ),
        .q        ( q        ),
        .busy     ( busy     ),
        .chk_req  ( chk_req  ),
        .chk_idx  ( chk_idx  ),
        .chk_name ( chk_name ),
        .chk_exp  ( chk_exp  ),
        .pass_cnt ( pass_cnt ),
        .fail_cnt ( fail_cnt )
    );

    always #4 CLK = ~CLK;

    // the limit is armed once the vectors are loaded
    always @(posedge CLK)
    begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit)
        begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Regression failed");
            $finish;
        end
    end

    // one clock edge, then the port returns to idle 1 ns later
    task automatic step;
        @(posedge CLK);
        #1;
        cen     = 1'b1;
        wen     = 1'b1;
        ben     = '1;
        clear   = 1'b0;
        chk_req = 1'b0;
    endtask

    task automatic expect_q(input int i);
        chk_req  = 1'b1;
        chk_idx  = i;
        chk_name = vec_name[i];
        chk_exp  = vec_exp[i];
    endtask

    task automatic load_vectors;
        int                fd;
        int                n;
        string             line;
        logic [NAME_W-1:0] name;
        logic [63:0]       op;
        addr_t             a;
        ben_t              b;
        word_t             wd;
        word_t             ex;
        fd = $fopen("dv/mem_vectors.txt", "r");
        if (fd == 0)
        begin
            $display("Error: cannot open the vector file dv/mem_vectors.txt");
            vec_errors++;
            return;
        end
        while (!$feof(fd))
        begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line.getc(0) == "#")
                continue;
            n = $sscanf(line, "%s %s %h %h %h %h", name, op, a, b, wd, ex);
            if (n != 6)
            begin
                $display("Error: vector line cannot be parsed: %s", line);
                vec_errors++;
            end
            else
            begin
                vec_name.push_back(name);
                vec_op.push_back(op);
                vec_addr.push_back(a);
                vec_ben.push_back(b);
                vec_data.push_back(wd);
                vec_exp.push_back(ex);
                if (op == "clear")
                    n_clear++;
            end
        end
        $fclose(fd);
    endtask

    task automatic run_vector(input int i);
        case (vec_op[i])
            "write":
            begin
                cen  = 1'b0;
                wen  = 1'b0;
                addr = vec_addr[i];
                ben  = vec_ben[i];
                d    = vec_data[i];
                step();
            end
            "read":
            begin
                cen  = 1'b0;
                addr = vec_addr[i];
                expect_q(i);
                step();
            end
            // check q on a cycle with no access at all
            "hold":
            begin
                expect_q(i);
                step();
            end
            "clear":
            begin
                clear = 1'b1;
                step();
            end
            "wait":
            begin
                while (busy)
                    step();
            end
            default:
            begin
                $display("Error: vector %0d has an unknown operation", i);
                vec_errors++;
            end
        endcase
    endtask

    initial
    begin
        CLK         = 1'b0;
        RSTN        = 1'b0;
        cen         = 1'b1;
        wen         = 1'b1;
        ben         = '1;
        addr        = '0;
        d           = '0;
        clear       = 1'b0;
        chk_req     = 1'b0;
        chk_idx     = 0;
        chk_name    = '0;
        chk_exp     = '0;
        n_clear     = 0;
        vec_errors  = 0;
        cycles      = 0;
        cycle_limit = 0;

        load_vectors();
        cycle_limit = CLEAR_CYCLES * (1 + n_clear) + 4 * vec_name.size() + 100;

        repeat (2) @(posedge CLK);
        #1;
        RSTN = 1'b1;

        for (int i = 0; i < vec_name.size(); i++)
            run_vector(i);

        // the last read is compared half a cycle after its edge
        repeat (2) step();

        $display("Tests: %0d passed, %0d failed, %0d vector errors", pass_cnt, fail_cnt,
                 vec_errors);
        if (fail_cnt == 0 && vec_errors == 0 && pass_cnt > 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// ==== dv/mem_vectors.txt ====
# columns: name, op, addr, ben (active low), write data, expected q; numbers in hex
# op is write, read, hold (check q with no access), clear or wait (until busy falls)
busy_wr_a     write 005 0 deadbeef 00000000
busy_wr_b     write 000 0 cafef00d 00000000
init_wait     wait  000 f 00000000 00000000
init_rd_000   read  000 f 00000000 00000000
init_rd_005   read  005 f 00000000 00000000
init_rd_1a7   read  1a7 f 00000000 00000000
init_rd_3ff   read  3ff f 00000000 00000000
full_wr       write 123 0 12345678 00000000
full_rd       read  123 f 00000000 12345678
part_base     write 040 0 11223344 00000000
part_wr_b0    write 040 e 000000aa 00000000
part_wr_b3    write 040 7 bb000000 00000000
part_rd       read  040 f 00000000 bb2233aa
part_wr_mid   write 040 9 00ccdd00 00000000
part_rd_mid   read  040 f 00000000 bbccddaa
cut0_wr       write 017 0 a0a0a0a0 00000000
cut1_wr       write 117 0 b1b1b1b1 00000000
cut2_wr       write 217 0 c2c2c2c2 00000000
cut3_wr       write 317 0 d3d3d3d3 00000000
cut0_rd       read  017 f 00000000 a0a0a0a0
cut1_rd       read  117 f 00000000 b1b1b1b1
cut2_rd       read  217 f 00000000 c2c2c2c2
cut3_rd       read  317 f 00000000 d3d3d3d3
idle_hold     hold  000 f 00000000 d3d3d3d3
wr_cut0       write 017 0 5a5a5a5a 00000000
wr_hold       hold  000 f 00000000 d3d3d3d3
cut0_rd_new   read  017 f 00000000 5a5a5a5a
clr_pulse     clear 000 f 00000000 00000000
clr_busy_wr_a write 002 0 deadbeef 00000000
clr_busy_wr_b write 000 0 cafef00d 00000000
clr_wait      wait  000 f 00000000 00000000
clr_hold      hold  000 f 00000000 5a5a5a5a
clr_rd_000    read  000 f 00000000 00000000
clr_rd_002    read  002 f 00000000 00000000
clr_rd_123    read  123 f 00000000 00000000
clr_rd_040    read  040 f 00000000 00000000
clr_rd_017    read  017 f 00000000 00000000
clr_rd_117    read  117 f 00000000 00000000
clr_rd_217    read  217 f 00000000 00000000
clr_rd_317    read  317 f 00000000 00000000

// ==== mem_subsys.f ====
+incdir+common
common/mem_pkg.sv
common/init_pkg.sv
sram_bank/mem_cut.sv
sram_bank/sram_bank.sv
logic/word_counter.sv
logic/init_sequencer.sv
logic/mem_subsys.sv
dv/mem_checker.sv
dv/tb_mem_subsys.sv

// ==== Makefile ====
SIM      := verilator
SIMFLAGS := --binary --timing --assert
TOP      := tb_mem_subsys
FILELIST := mem_subsys.f
OBJDIR   := obj_dir

BIN      := $(OBJDIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf $(OBJDIR)
